//--- Bender.yml
package:
  name: gc_unit

sources:
  - files:
      - hw/gc_pkg.sv
      - hw/one_hot_mux.sv
      - hw/exception_select.sv
      - hw/gc_decode.sv
      - hw/gc_fsm.sv
      - hw/gc_unit.sv
  - target: simulation
    files:
      - sim/gc_unit_tb.sv

//--- filelist.f
hw/gc_pkg.sv
hw/one_hot_mux.sv
hw/exception_select.sv
hw/gc_decode.sv
hw/gc_fsm.sv
hw/gc_unit.sv
sim/gc_unit_tb.sv

//--- hw/exception_select.sv
`timescale 1ns/1ns

module exception_select #(
    parameter int NUM_SOURCES = 3
) (
    input gc_pkg::exception_src_t [NUM_SOURCES-1:0] sources,
    output gc_pkg::exception_out_t exception,
    output logic possible_exception
);
    import gc_pkg::*;

    logic [NUM_SOURCES-1:0] src_valid;
    logic [NUM_SOURCES-1:0] src_possible;
    exception_code_t [NUM_SOURCES-1:0] src_code;
    logic [NUM_SOURCES-1:0][31:0] src_tval;
    logic [NUM_SOURCES-1:0][31:0] src_pc;

    // Split the structs into plain vectors so each field can be muxed
    for (genvar i = 0; i < NUM_SOURCES; i++) begin : gen_unpack
        assign src_valid[i]    = sources[i].valid;
        assign src_possible[i] = sources[i].possible;
        assign src_code[i]     = sources[i].code;
        assign src_tval[i]     = sources[i].tval;
        assign src_pc[i]       = sources[i].pc;
    end

    // Any source that may still fault keeps the core from moving on
    assign possible_exception = |src_possible;
    assign exception.valid = |src_valid;

    one_hot_mux #(.OPTIONS(NUM_SOURCES), .data_t(exception_code_t)) u_code_mux (
        .one_hot (src_valid),
        .choices (src_code),
        .sel     (exception.code)
    );

    one_hot_mux #(.OPTIONS(NUM_SOURCES), .data_t(logic [31:0])) u_tval_mux (
        .one_hot (src_valid),
        .choices (src_tval),
        .sel     (exception.tval)
    );

    one_hot_mux #(.OPTIONS(NUM_SOURCES), .data_t(logic [31:0])) u_pc_mux (
        .one_hot (src_valid),
        .choices (src_pc),
        .sel     (exception.pc)
    );

endmodule

//--- hw/gc_decode.sv
`timescale 1ns/1ns

module gc_decode (
    input logic clk,
    input logic rst,
    input logic issue_req,
    input logic [31:0] instr,
    input logic [31:0] pc,
    input logic [31:0] rs1_data,
    input gc_pkg::privilege_t privilege,
    input logic tvm,
    input logic tsr,
    input logic [31:0] mepc,
    input logic [31:0] sepc,
    output gc_pkg::gc_cmd_t cmd,
    output gc_pkg::exception_src_t local_exception
);
    import gc_pkg::*;

    localparam logic [2:0] FENCEI_FN3 = 3'b001;

    logic is_mret;
    logic is_sret;
    logic is_sfence;
    logic is_ifence;
    logic illegal;
    logic legal_issue;

    logic ifence_r;
    logic sfence_r;
    logic mret_r;
    logic sret_r;
    logic flush_r;
    logic exc_valid_r;
    logic addr_only_r;
    logic [31:0] target_r;
    logic [31:0] sfence_addr_r;
    logic [31:0] instr_r;
    logic [31:0] pc_r;

    ////////////////////////////////////////////////////////////////////////////
    // Classify
    assign is_mret = instr == MRET_INSTR;
    assign is_sret = instr == SRET_INSTR;
    // SFENCE.VMA with rd and funct3 zero
    assign is_sfence = (instr[6:0] == SYSTEM_OPCODE) & (instr[31:25] == SFENCE_FN7) &
                       (instr[14:12] == 3'b000) & (instr[11:7] == 5'd0);
    assign is_ifence = (instr[6:0] == MISC_MEM_OPCODE) & (instr[14:12] == FENCEI_FN3);

    // Privilege checks
    always_comb begin
        case (privilege)
            USER_PRIV: illegal = is_sfence | is_sret | is_mret;
            SUPERVISOR_PRIV: illegal = (is_sfence & tvm) | (is_sret & tsr);
            MACHINE_PRIV: illegal = 1'b0;
            default: illegal = 1'b0;
        endcase
    end

    // WFI is accepted but needs no front-end action
    assign legal_issue = issue_req & ~illegal;

    ////////////////////////////////////////////////////////////////////////////
    // Command pulses one cycle after issue
    always_ff @(posedge clk) begin
        if (rst) begin
            ifence_r <= 1'b0;
            sfence_r <= 1'b0;
            mret_r <= 1'b0;
            sret_r <= 1'b0;
            flush_r <= 1'b0;
            exc_valid_r <= 1'b0;
        end else begin
            ifence_r <= legal_issue & is_ifence;
            sfence_r <= legal_issue & is_sfence;
            mret_r <= legal_issue & is_mret;
            sret_r <= legal_issue & is_sret;
            flush_r <= legal_issue & (is_ifence | is_sfence | is_mret | is_sret);
            exc_valid_r <= issue_req & illegal;
        end
    end

    // Payload
    always_ff @(posedge clk) begin
        if (issue_req) begin
            instr_r <= instr;
            pc_r <= pc;
        end
        if (legal_issue) begin
            addr_only_r <= |instr[19:15];
            sfence_addr_r <= rs1_data;
            target_r <= is_mret ? mepc : (is_sret ? sepc : pc + 32'd4);
        end else if (sfence_r) begin
            // Target carries the flush address once the PC override is done
            target_r <= sfence_addr_r;
        end
    end

    assign cmd = '{
        ifence: ifence_r,
        sfence: sfence_r,
        mret: mret_r,
        sret: sret_r,
        flush: flush_r,
        addr_only: addr_only_r,
        target: target_r
    };

    // Raised on the first cycle, so never reported as possible
    assign local_exception = '{
        valid: exc_valid_r,
        possible: 1'b0,
        code: ILLEGAL_INST,
        tval: instr_r,
        pc: pc_r
    };

endmodule

//--- hw/gc_fsm.sv
`timescale 1ns/1ns

module gc_fsm #(
    parameter int INIT_CLEAR_DEPTH = 8,
    parameter int TLB_CLEAR_DEPTH = 4
) (
    input logic clk,
    input logic rst,
    input gc_pkg::gc_cmd_t cmd,
    input gc_pkg::exception_out_t exception,
    input logic possible_exception,
    input logic interrupt_pending,
    input logic issue_valid,
    input logic outstanding_store,
    input logic [31:0] trap_vector,
    output gc_pkg::gc_outputs_t gc,
    output gc_pkg::sfence_t sfence,
    output logic interrupt_taken
);

    typedef enum logic [2:0] {
        RST,
        PRE_CLEAR,
        INIT_CLEAR,
        IDLE,
        WAIT_INTERRUPT,
        PRE_ISSUE_FLUSH,
        TLB_CLEAR,
        WAIT_WRITE
    } state_t;

    // Counter wide enough for the init clear, TLB clear reuses its low bits
    localparam int CNT_W = $clog2(INIT_CLEAR_DEPTH) + 1;

    state_t state;
    state_t next_state;
    logic [CNT_W-1:0] clear_count;
    logic init_clear_done;
    logic tlb_clear_done;

    logic sfence_pend;
    logic ifence_pend;
    logic addr_only_r;

    logic fetch_hold_r;
    logic issue_hold_r;
    logic init_clear_r;
    logic tlb_flush_r;
    logic trap_override_r;
    logic [31:0] trap_pc_r;

    // Take the interrupt once nothing older can still fault
    assign interrupt_taken = (state == WAIT_INTERRUPT) & interrupt_pending & issue_valid &
                             ~possible_exception & ~exception.valid & ~cmd.flush;

    ////////////////////////////////////////////////////////////////////////////
    // State machine
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= RST;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            RST: next_state = PRE_CLEAR;
            PRE_CLEAR: next_state = INIT_CLEAR;
            INIT_CLEAR: if (init_clear_done) next_state = IDLE;
            IDLE: begin
                if (cmd.flush | exception.valid) begin
                    next_state = PRE_ISSUE_FLUSH;
                end else if (interrupt_pending) begin
                    next_state = WAIT_INTERRUPT;
                end
            end
            WAIT_INTERRUPT: begin
                // Exception or a late command wins over the interrupt
                if (cmd.flush | exception.valid | interrupt_taken) begin
                    next_state = PRE_ISSUE_FLUSH;
                end else if (~interrupt_pending) begin
                    next_state = IDLE;
                end
            end
            PRE_ISSUE_FLUSH: begin
                if (sfence_pend) begin
                    next_state = TLB_CLEAR;
                end else if (ifence_pend) begin
                    next_state = WAIT_WRITE;
                end else begin
                    next_state = IDLE;
                end
            end
            TLB_CLEAR: begin
                if (tlb_clear_done) begin
                    next_state = outstanding_store ? WAIT_WRITE : IDLE;
                end
            end
            WAIT_WRITE: if (~outstanding_store) next_state = IDLE;
            default: next_state = RST;
        endcase
    end

    // Fence kind kept past the one-cycle command
    always_ff @(posedge clk) begin
        if (rst) begin
            sfence_pend <= 1'b0;
            ifence_pend <= 1'b0;
            addr_only_r <= 1'b0;
        end else if (cmd.flush & ~exception.valid) begin
            sfence_pend <= cmd.sfence;
            ifence_pend <= cmd.ifence;
            addr_only_r <= cmd.sfence & cmd.addr_only;
        end else if (next_state == IDLE) begin
            sfence_pend <= 1'b0;
            ifence_pend <= 1'b0;
            addr_only_r <= 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Clear counter
    always_ff @(posedge clk) begin
        if (rst || next_state == IDLE) begin
            clear_count <= '0;
        end else if (next_state inside {INIT_CLEAR, TLB_CLEAR}) begin
            clear_count <= clear_count + 1'b1;
        end
    end

    assign init_clear_done = clear_count[CNT_W-1];
    // Single address flush needs one cycle only
    assign tlb_clear_done = clear_count[$clog2(TLB_CLEAR_DEPTH)] | addr_only_r;

    ////////////////////////////////////////////////////////////////////////////
    // Registered controls
    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_hold_r <= 1'b1;
            issue_hold_r <= 1'b1;
            init_clear_r <= 1'b0;
            tlb_flush_r <= 1'b0;
            trap_override_r <= 1'b0;
        end else begin
            fetch_hold_r <= next_state inside {PRE_CLEAR, INIT_CLEAR, PRE_ISSUE_FLUSH,
                                               TLB_CLEAR, WAIT_WRITE};
            issue_hold_r <= next_state inside {PRE_CLEAR, INIT_CLEAR, WAIT_INTERRUPT,
                                               PRE_ISSUE_FLUSH, TLB_CLEAR, WAIT_WRITE};
            init_clear_r <= next_state == INIT_CLEAR;
            tlb_flush_r <= next_state inside {INIT_CLEAR, TLB_CLEAR};
            trap_override_r <= exception.valid | interrupt_taken;
        end
    end

    // Trap target, redirect follows one cycle later
    always_ff @(posedge clk) begin
        if (exception.valid | interrupt_taken) begin
            trap_pc_r <= trap_vector;
        end
    end

    // Commands redirect in the cycle they appear
    assign gc = '{
        fetch_hold: fetch_hold_r,
        issue_hold: issue_hold_r | possible_exception,
        init_clear: init_clear_r,
        fetch_ifence: cmd.ifence,
        pc_override: cmd.flush | trap_override_r,
        pc: cmd.flush ? cmd.target : trap_pc_r
    };

    assign sfence = '{
        valid: tlb_flush_r,
        addr_only: addr_only_r,
        addr: cmd.target
    };

endmodule

//--- hw/gc_pkg.sv
package gc_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Privilege levels
    typedef logic [1:0] privilege_t;

    localparam privilege_t USER_PRIV       = 2'b00;
    localparam privilege_t SUPERVISOR_PRIV = 2'b01;
    localparam privilege_t MACHINE_PRIV    = 2'b11;

    ////////////////////////////////////////////////////////////////////////////
    // Trap causes, synchronous exceptions only
    typedef logic [4:0] exception_code_t;

    localparam exception_code_t INST_ADDR_MISALIGNED = 5'd0;
    localparam exception_code_t ILLEGAL_INST         = 5'd2;
    localparam exception_code_t BREAKPOINT           = 5'd3;
    localparam exception_code_t LOAD_ADDR_MISALIGNED = 5'd4;
    localparam exception_code_t LOAD_FAULT           = 5'd5;
    localparam exception_code_t STORE_AMO_FAULT      = 5'd7;

    ////////////////////////////////////////////////////////////////////////////
    // Instruction encodings
    // Returns and WFI are matched on the whole word
    localparam logic [31:0] MRET_INSTR = 32'h3020_0073;
    localparam logic [31:0] SRET_INSTR = 32'h1020_0073;
    localparam logic [31:0] WFI_INSTR  = 32'h1050_0073;

    localparam logic [6:0] SYSTEM_OPCODE   = 7'b1110011;
    localparam logic [6:0] MISC_MEM_OPCODE = 7'b0001111;
    localparam logic [6:0] SFENCE_FN7      = 7'b0001001;

    // One exception source as seen by the selector
    typedef struct packed {
        logic valid;
        logic possible;
        exception_code_t code;
        logic [31:0] tval;
        logic [31:0] pc;
    } exception_src_t;

    // Selected exception
    typedef struct packed {
        logic valid;
        exception_code_t code;
        logic [31:0] tval;
        logic [31:0] pc;
    } exception_out_t;

    // Registered command from the issue stage
    typedef struct packed {
        logic ifence;
        logic sfence;
        logic mret;
        logic sret;
        logic flush;
        logic addr_only;
        logic [31:0] target;
    } gc_cmd_t;

    // TLB flush request
    typedef struct packed {
        logic valid;
        logic addr_only;
        logic [31:0] addr;
    } sfence_t;

    // Global controls to the rest of the core
    typedef struct packed {
        logic fetch_hold;
        logic issue_hold;
        logic init_clear;
        logic fetch_ifence;
        logic pc_override;
        logic [31:0] pc;
    } gc_outputs_t;

endpackage

//--- hw/gc_unit.sv
`timescale 1ns/1ns

module gc_unit #(
    parameter int NUM_EXT_EXCEPTIONS = 2,
    parameter int INIT_CLEAR_DEPTH = 8,
    parameter int TLB_CLEAR_DEPTH = 4
) (
    input logic clk,
    input logic rst,

    // Issue stage
    input logic issue_req,
    input logic [31:0] instr,
    input logic [31:0] pc,
    input logic [31:0] rs1_data,
    input logic issue_valid,

    // Privilege state
    input gc_pkg::privilege_t privilege,
    input logic tvm,
    input logic tsr,
    input logic [31:0] mepc,
    input logic [31:0] sepc,

    // Traps and ordering
    input gc_pkg::exception_src_t [NUM_EXT_EXCEPTIONS-1:0] ext_exceptions,
    input logic interrupt_pending,
    input logic outstanding_store,
    input logic [31:0] trap_vector,

    output gc_pkg::gc_outputs_t gc,
    output gc_pkg::exception_out_t exception,
    output gc_pkg::sfence_t sfence,
    output logic mret,
    output logic sret,
    output logic interrupt_taken
);
    import gc_pkg::*;

    gc_cmd_t cmd;
    exception_src_t local_exception;
    exception_src_t [NUM_EXT_EXCEPTIONS:0] all_sources;
    logic possible_exception;

    gc_decode u_decode (
        .clk             (clk),
        .rst             (rst),
        .issue_req       (issue_req),
        .instr           (instr),
        .pc              (pc),
        .rs1_data        (rs1_data),
        .privilege       (privilege),
        .tvm             (tvm),
        .tsr             (tsr),
        .mepc            (mepc),
        .sepc            (sepc),
        .cmd             (cmd),
        .local_exception (local_exception)
    );

    // Local illegal-instruction source sits at the top index
    assign all_sources = {local_exception, ext_exceptions};

    exception_select #(.NUM_SOURCES(NUM_EXT_EXCEPTIONS + 1)) u_select (
        .sources            (all_sources),
        .exception          (exception),
        .possible_exception (possible_exception)
    );

    gc_fsm #(
        .INIT_CLEAR_DEPTH (INIT_CLEAR_DEPTH),
        .TLB_CLEAR_DEPTH  (TLB_CLEAR_DEPTH)
    ) u_fsm (
        .clk                (clk),
        .rst                (rst),
        .cmd                (cmd),
        .exception          (exception),
        .possible_exception (possible_exception),
        .interrupt_pending  (interrupt_pending),
        .issue_valid        (issue_valid),
        .outstanding_store  (outstanding_store),
        .trap_vector        (trap_vector),
        .gc                 (gc),
        .sfence             (sfence),
        .interrupt_taken    (interrupt_taken)
    );

    assign mret = cmd.mret;
    assign sret = cmd.sret;

endmodule

//--- hw/one_hot_mux.sv
`timescale 1ns/1ns

module one_hot_mux #(
    parameter int OPTIONS = 2,
    parameter type data_t = logic
) (
    input logic [OPTIONS-1:0] one_hot,
    input data_t [OPTIONS-1:0] choices,
    output data_t sel
);

    // AND-OR select, zero when no bit is set
    always_comb begin
        sel = '0;
        for (int i = 0; i < OPTIONS; i++) begin
            if (one_hot[i]) begin
                sel = sel | choices[i];
            end
        end
    end

endmodule

//--- sim/gc_patterns.txt
# kind instr priv tvm tsr rs1_data pc store ext_src exp_pc exp_exc, all hex
# kind 1 issues instr, 2 fires ext_src (instr is tval, rs1_data is code), 3 interrupt
# kind 3 holds the source's possible bit for store cycles; exp_pc 0 means no redirect
1 30200073 3 0 0 00000000 00000400 0 0 80001000 0
1 10200073 3 0 0 00000000 00000420 0 0 80002000 0
1 10200073 0 0 0 00000000 00000440 0 0 00000100 1
1 30200073 0 0 0 00000000 00000460 0 0 00000100 1
1 12028073 1 1 0 00001000 00000480 0 0 00000100 1
1 10200073 1 0 1 00000000 000004a0 0 0 00000100 1
1 10200073 1 0 0 00000000 000004c0 0 0 80002000 0
1 30200073 1 0 0 00000000 000004e0 0 0 80001000 0
1 12028073 3 0 0 deadbee0 00000500 5 0 00000504 0
1 12000073 3 0 0 00000000 00000520 3 0 00000524 0
1 12028073 1 0 0 00042000 00000540 0 0 00000544 0
1 0000100f 3 0 0 00000000 00000560 6 0 00000564 0
1 0000100f 0 0 0 00000000 00000580 0 0 00000584 0
1 10500073 3 0 0 00000000 000005a0 0 0 00000000 0
1 10500073 0 0 0 00000000 000005c0 0 0 00000000 0
1 12000073 0 0 0 00000000 000005e0 2 0 00000100 1
2 cafe0001 3 0 0 00000005 00002000 0 0 00000100 1
2 0badf00d 3 0 0 00000007 00003000 0 1 00000100 1
3 00000000 3 0 0 00000000 00000000 4 1 00000100 0
3 00000000 3 0 0 00000000 00000000 2 0 00000100 0

//--- sim/gc_unit_tb.sv
`timescale 1ns/1ns

module gc_unit_tb;
    import gc_pkg::*;

    localparam int NUM_EXT = 2;
    localparam int INIT_DEPTH = 8;
    localparam int TLB_DEPTH = 4;
    localparam int CLK_PERIOD = 20;
    localparam int RESET_CYCLES = 10;
    localparam int MAX_TESTS = 32;
    // Mean cycle budget per pattern line, filler included
    localparam int TEST_BUDGET = 10;
    localparam int IDLE_LIMIT = 24;
    localparam int TAKE_LIMIT = 8;

    // Return addresses and trap vector seen by the DUT
    localparam logic [31:0] MEPC = 32'h8000_1000;
    localparam logic [31:0] SEPC = 32'h8000_2000;
    localparam logic [31:0] TRAP_VEC = 32'h0000_0100;

    // RISC-V encodings used to work out the expected pulses
    localparam logic [31:0] MRET_WORD = 32'h3020_0073;
    localparam logic [31:0] SRET_WORD = 32'h1020_0073;
    localparam logic [4:0] ILLEGAL_CAUSE = 5'd2;

    // One line of the pattern file
    typedef struct packed {
        logic [3:0] kind;
        logic [31:0] instr;
        logic [1:0] priv;
        logic tvm;
        logic tsr;
        logic [31:0] rs1_data;
        logic [31:0] pc;
        logic [7:0] store_cycles;
        logic [3:0] ext_src;
        logic [31:0] exp_pc;
        logic exp_exc;
    } pattern_t;

    logic clk;
    logic rst;
    logic issue_req;
    logic [31:0] instr;
    logic [31:0] pc;
    logic [31:0] rs1_data;
    logic issue_valid;
    privilege_t privilege;
    logic tvm;
    logic tsr;
    logic [31:0] mepc;
    logic [31:0] sepc;
    exception_src_t [NUM_EXT-1:0] ext_exceptions;
    logic interrupt_pending;
    logic outstanding_store;
    logic [31:0] trap_vector;

    gc_outputs_t gc;
    exception_out_t exception;
    sfence_t sfence;
    logic mret;
    logic sret;
    logic interrupt_taken;

    pattern_t patterns [MAX_TESTS];
    int num_tests;
    int errors;
    int test_errors;
    int failed_tests;
    logic [31:0] rng;
    bit loaded = 1'b0;

    gc_unit u_dut (
        .clk               (clk),
        .rst               (rst),
        .issue_req         (issue_req),
        .instr             (instr),
        .pc                (pc),
        .rs1_data          (rs1_data),
        .issue_valid       (issue_valid),
        .privilege         (privilege),
        .tvm               (tvm),
        .tsr               (tsr),
        .mepc              (mepc),
        .sepc              (sepc),
        .ext_exceptions    (ext_exceptions),
        .interrupt_pending (interrupt_pending),
        .outstanding_store (outstanding_store),
        .trap_vector       (trap_vector),
        .gc                (gc),
        .exception         (exception),
        .sfence            (sfence),
        .mret              (mret),
        .sret              (sret),
        .interrupt_taken   (interrupt_taken)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // Reporting helpers

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("CHECK FAILED %s: got %h, expected %h", name, actual, expected);
            errors++;
            test_errors++;
        end
    endtask

    task automatic report_failure(input string what);
        $display("ERROR: %s", what);
        errors++;
        test_errors++;
    endtask

    task automatic report_test(input int num, input string what);
        if (test_errors == 0) begin
            $display("test %0d %s: ok", num, what);
        end else begin
            failed_tests++;
            $display("test %0d %s: %0d errors", num, what, test_errors);
        end
    endtask

    task automatic end_run();
        $display("%0d tests run, %0d failed, %0d errors", num_tests + 1, failed_tests, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    endtask

    // 32-bit xorshift for filler instructions
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Lines of the pattern file that do not parse as 11 hex fields are skipped

    task automatic load_patterns(output bit ok);
        int fd;
        int n;
        logic [31:0] f [11];
        reg [8*160-1:0] line;
        ok = 1'b0;
        num_tests = 0;
        fd = $fopen("sim/gc_patterns.txt", "r");
        if (fd == 0) begin
            return;
        end
        while (!$feof(fd) && num_tests < MAX_TESTS) begin
            line = '0;
            n = $fgets(line, fd);
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h", f[0], f[1], f[2], f[3],
                        f[4], f[5], f[6], f[7], f[8], f[9], f[10]);
            if (n == 11) begin
                patterns[num_tests] = '{
                    kind: f[0][3:0],
                    instr: f[1],
                    priv: f[2][1:0],
                    tvm: f[3][0],
                    tsr: f[4][0],
                    rs1_data: f[5],
                    pc: f[6],
                    store_cycles: f[7][7:0],
                    ext_src: f[8][3:0],
                    exp_pc: f[9],
                    exp_exc: f[10][0]
                };
                num_tests++;
            end
        end
        $fclose(fd);
        ok = num_tests > 0;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Test sequences

    task automatic wait_idle();
        bit idle;
        idle = 1'b0;
        for (int i = 0; i < IDLE_LIMIT && !idle; i++) begin
            @(posedge clk);
            @(negedge clk);
            idle = !gc.fetch_hold && !gc.issue_hold && !gc.pc_override;
        end
        if (!idle) report_failure("unit did not return to idle");
    endtask

    // Holds and clears rise after reset and are all gone within INIT_DEPTH+4 cycles
    task automatic run_reset_test();
        bit saw_clear;
        bit done;
        saw_clear = 1'b0;
        done = 1'b0;
        repeat (RESET_CYCLES - 1) @(posedge clk);
        @(negedge clk);
        check_value("gc.fetch_hold in reset", gc.fetch_hold, 1'b1);
        @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < INIT_DEPTH + 4 && !done; i++) begin
            @(posedge clk);
            @(negedge clk);
            if (gc.init_clear) begin
                saw_clear = 1'b1;
                check_value("gc.fetch_hold", gc.fetch_hold, 1'b1);
                check_value("gc.issue_hold", gc.issue_hold, 1'b1);
                check_value("sfence.valid", sfence.valid, 1'b1);
            end
            done = saw_clear && !gc.fetch_hold && !gc.issue_hold && !gc.init_clear &&
                   !sfence.valid;
        end
        if (!saw_clear) report_failure("init clear never started after reset");
        if (!done) report_failure("holds still high after the init clear window");
    endtask

    task automatic run_issue_test(input pattern_t p);
        bit is_mret;
        bit is_sret;
        bit is_sfence;
        bit is_fencei;
        bit legal;
        bit done;
        int c;
        int tlb_cycles;
        is_mret = p.instr == MRET_WORD;
        is_sret = p.instr == SRET_WORD;
        // SFENCE.VMA has funct7 0001001, funct3 and rd zero
        is_sfence = p.instr[6:0] == 7'h73 && p.instr[31:25] == 7'b0001001 &&
                    p.instr[14:7] == 8'd0;
        is_fencei = p.instr[6:0] == 7'h0f && p.instr[14:12] == 3'b001;
        legal = !p.exp_exc;
        done = 1'b0;
        tlb_cycles = 0;

        @(posedge clk);
        issue_req <= 1'b1;
        instr <= p.instr;
        pc <= p.pc;
        rs1_data <= p.rs1_data;
        privilege <= p.priv;
        tvm <= p.tvm;
        tsr <= p.tsr;
        outstanding_store <= p.store_cycles != 0;
        @(posedge clk);
        issue_req <= 1'b0;

        // Cycle k+1
        @(negedge clk);
        check_value("exception.valid", exception.valid, p.exp_exc);
        check_value("mret", mret, legal && is_mret);
        check_value("sret", sret, legal && is_sret);
        check_value("gc.fetch_ifence", gc.fetch_ifence, legal && is_fencei);
        check_value("gc.pc_override", gc.pc_override, legal && p.exp_pc != 0);
        if (p.exp_exc) begin
            check_value("exception.code", exception.code, ILLEGAL_CAUSE);
            check_value("exception.tval", exception.tval, p.instr);
            check_value("exception.pc", exception.pc, p.pc);
        end else if (p.exp_pc != 0) begin
            check_value("gc.pc", gc.pc, p.exp_pc);
        end

        // From k+2 on, follow the flush until the unit is idle again
        for (c = 2; c < IDLE_LIMIT && !done; c++) begin
            @(posedge clk);
            if (c - 1 >= p.store_cycles) outstanding_store <= 1'b0;
            @(negedge clk);
            if (c == 2) begin
                // Command pulses last one cycle only
                check_value("mret", mret, 1'b0);
                check_value("sret", sret, 1'b0);
                check_value("gc.fetch_ifence", gc.fetch_ifence, 1'b0);
                check_value("gc.pc_override", gc.pc_override, p.exp_exc);
                if (p.exp_exc) check_value("gc.pc", gc.pc, p.exp_pc);
            end
            if (sfence.valid) begin
                tlb_cycles++;
                if (legal && is_sfence) begin
                    check_value("sfence.addr_only", sfence.addr_only, |p.instr[19:15]);
                    if (|p.instr[19:15]) check_value("sfence.addr", sfence.addr, p.rs1_data);
                end
            end
            if (outstanding_store && legal && (is_sfence || is_fencei)) begin
                check_value("gc.fetch_hold", gc.fetch_hold, 1'b1);
            end
            done = c > 2 && !outstanding_store && !gc.fetch_hold && !gc.issue_hold;
        end
        if (!done) report_failure("unit did not return to idle after the instruction");

        // Single address flush lasts one cycle and a full flush up to TLB_DEPTH+1
        if (legal && is_sfence && |p.instr[19:15]) begin
            check_value("sfence.valid cycles", tlb_cycles, 1);
        end else if (legal && is_sfence) begin
            if (tlb_cycles < 1 || tlb_cycles > TLB_DEPTH + 1) begin
                report_failure("full TLB flush length out of range");
            end
        end else begin
            check_value("sfence.valid cycles", tlb_cycles, 0);
        end
    endtask

    // External source fired with the instr column as tval and the rs1_data column as code
    task automatic run_exception_test(input pattern_t p);
        @(posedge clk);
        ext_exceptions[p.ext_src] <= '{
            valid: 1'b1,
            possible: 1'b0,
            code: p.rs1_data[4:0],
            tval: p.instr,
            pc: p.pc
        };
        @(negedge clk);
        check_value("exception.valid", exception.valid, p.exp_exc);
        check_value("exception.code", exception.code, p.rs1_data[4:0]);
        check_value("exception.tval", exception.tval, p.instr);
        check_value("exception.pc", exception.pc, p.pc);
        @(posedge clk);
        ext_exceptions <= '0;
        @(negedge clk);
        check_value("gc.pc_override", gc.pc_override, 1'b1);
        check_value("gc.pc", gc.pc, p.exp_pc);
        wait_idle();
    endtask

    // Interrupt held off while a source may still fault
    task automatic run_interrupt_test(input pattern_t p);
        bit taken;
        taken = 1'b0;
        @(posedge clk);
        ext_exceptions[p.ext_src].possible <= 1'b1;
        interrupt_pending <= 1'b1;
        repeat (p.store_cycles) begin
            @(negedge clk);
            check_value("gc.issue_hold", gc.issue_hold, 1'b1);
            check_value("interrupt_taken", interrupt_taken, 1'b0);
            @(posedge clk);
        end
        ext_exceptions <= '0;
        for (int i = 0; i < TAKE_LIMIT && !taken; i++) begin
            @(negedge clk);
            taken = interrupt_taken;
            if (!taken) @(posedge clk);
        end
        @(posedge clk);
        interrupt_pending <= 1'b0;
        @(negedge clk);
        if (!taken) begin
            report_failure("interrupt not taken after the possible bit cleared");
        end else begin
            check_value("gc.pc_override", gc.pc_override, 1'b1);
            check_value("gc.pc", gc.pc, p.exp_pc);
            check_value("exception.valid", exception.valid, p.exp_exc);
        end
        wait_idle();
    endtask

    // Random ALU instruction between tests leaves the front end alone
    task automatic issue_filler();
        rng = xorshift32(rng);
        @(posedge clk);
        issue_req <= 1'b1;
        instr <= {rng[31:7], 7'b0110011};
        pc <= {rng[31:2], 2'b00};
        privilege <= MACHINE_PRIV;
        @(posedge clk);
        issue_req <= 1'b0;
        @(negedge clk);
        check_value("gc.pc_override after filler", gc.pc_override, 1'b0);
        check_value("exception.valid after filler", exception.valid, 1'b0);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence

    initial begin
        bit ok;
        rst = 1'b1;
        issue_req = 1'b0;
        instr = '0;
        pc = '0;
        rs1_data = '0;
        issue_valid = 1'b1;
        privilege = MACHINE_PRIV;
        tvm = 1'b0;
        tsr = 1'b0;
        mepc = MEPC;
        sepc = SEPC;
        ext_exceptions = '0;
        interrupt_pending = 1'b0;
        outstanding_store = 1'b0;
        trap_vector = TRAP_VEC;
        errors = 0;
        failed_tests = 0;
        test_errors = 0;
        rng = 32'd76;
        load_patterns(ok);
        if (ok) begin
            loaded = 1'b1;
            run_reset_test();
            report_test(0, "reset clear");
            for (int t = 0; t < num_tests; t++) begin
                test_errors = 0;
                case (patterns[t].kind)
                    4'd1: run_issue_test(patterns[t]);
                    4'd2: run_exception_test(patterns[t]);
                    4'd3: run_interrupt_test(patterns[t]);
                    default: report_failure("unknown test kind in pattern file");
                endcase
                issue_filler();
                report_test(t + 1, patterns[t].kind == 4'd1 ? "system instruction" :
                            patterns[t].kind == 4'd2 ? "external exception" : "interrupt");
            end
        end else begin
            report_failure("could not read sim/gc_patterns.txt");
        end
        end_run();
    end

    // Watchdog sized from the number of pattern lines
    initial begin
        int limit_ns;
        wait (loaded);
        limit_ns = (RESET_CYCLES + INIT_DEPTH + 4 + num_tests * TEST_BUDGET) * CLK_PERIOD;
        #(limit_ns);
        report_failure("watchdog expired before the tests finished");
        end_run();
    end

endmodule
